// File: bru_pkg.sv
// width constants, operation, control-flow and address enums, branch structs and helper
package bru_pkg;

  // data and address width of the execute unit
  localparam int unsigned XLEN = 32;

  // cause code reported for a jump or taken branch to a misaligned target
  localparam logic [4:0] INSTR_ADDR_MISALIGNED = 5'd0;

  // control-flow operations handled by the branch unit
  // the first six are conditional, the last two always jump
  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd2,
    BGE  = 3'd3,
    BLTU = 3'd4,
    BGEU = 3'd5,
    JAL  = 3'd6,
    JALR = 3'd7
  } fu_op_e;

  // control-flow type, used both as the front end's guess and as the
  // resolved type that selects which predictor gets updated
  typedef enum logic [2:0] {
    NO_CF  = 3'd0,
    BRANCH = 3'd1,
    JUMP   = 3'd2,
    JUMP_R = 3'd3,
    RETURN = 3'd4
  } cf_e;

  // configuration register map, one word per address
  typedef enum logic [1:0] {
    CFG_CTRL       = 2'd0,
    CFG_RESOLVED   = 2'd1,
    CFG_MISPREDICT = 2'd2
  } cfg_addr_e;

  // prediction that travelled with the instruction from fetch
  typedef struct packed {
    cf_e             cf;
    logic [XLEN-1:0] predict_address;
  } predict_t;

  // one issued control-flow instruction, imm is already sign-extended
  typedef struct packed {
    fu_op_e          op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic            is_compressed;
    predict_t        predict;
  } br_req_t;

  // item held in the compare register stage
  typedef struct packed {
    logic    valid;
    br_req_t req;
    logic    comp_res;
  } br_stage_t;

  // resolution sent back towards the front end and the counters
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target_address;
    logic            is_taken;
    logic            is_mispredict;
    cf_e             cf_type;
  } resolve_t;

  // exception raised by the branch unit
  typedef struct packed {
    logic            valid;
    logic [4:0]      cause;
    logic [XLEN-1:0] tval;
  } exc_t;

  // true for the six conditional branch operations
  function automatic logic op_is_branch(input fu_op_e op);
    logic is_br;
    case (op)
      BEQ, BNE, BLT, BGE, BLTU, BGEU: is_br = 1'b1;
      default:                        is_br = 1'b0;
    endcase
    return is_br;
  endfunction

endpackage

// File: branch_compare.sv
// issue register stage with the branch comparison for conditional operations
`timescale 1ns/1ps

module branch_compare (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               issue_valid_i,
  input  bru_pkg::br_req_t   issue_req_i,
  output bru_pkg::br_stage_t stage_o
);

  // comparison outcome of the incoming request, before the register
  logic             comp_res;

  // registered stage contents
  logic             valid_q;
  bru_pkg::br_req_t req_q;
  logic             comp_res_q;

  // evaluate the condition on the issue side so that the branch unit only
  // sees a single bit after the register
  always_comb begin
    case (issue_req_i.op)
      bru_pkg::BEQ:  comp_res = issue_req_i.operand_a == issue_req_i.operand_b;
      bru_pkg::BNE:  comp_res = issue_req_i.operand_a != issue_req_i.operand_b;
      // signed compares reinterpret both operands as two's complement
      bru_pkg::BLT:  comp_res = $signed(issue_req_i.operand_a) <
                                $signed(issue_req_i.operand_b);
      bru_pkg::BGE:  comp_res = $signed(issue_req_i.operand_a) >=
                                $signed(issue_req_i.operand_b);
      bru_pkg::BLTU: comp_res = issue_req_i.operand_a < issue_req_i.operand_b;
      bru_pkg::BGEU: comp_res = issue_req_i.operand_a >= issue_req_i.operand_b;
      // jumps carry no condition, the branch unit treats them as taken anyway
      default:       comp_res = 1'b0;
    endcase
  end

  // the valid bit is high for exactly one cycle after each sampled issue
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid_i;
    end
  end

  // the request and its comparison outcome are loaded when an issue is sampled
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      req_q      <= issue_req_i;
      comp_res_q <= comp_res;
    end
  end

  // drive the stage item field by field
  always_comb begin
    stage_o.valid    = valid_q;
    stage_o.req      = req_q;
    stage_o.comp_res = comp_res_q;
  end

endmodule

// File: branch_unit.sv
// branch target, link value, mispredict resolution and misaligned-target exception
`timescale 1ns/1ps

module branch_unit (
  input  bru_pkg::br_stage_t       stage_i,
  input  logic                     rvc_en_i,
  output bru_pkg::resolve_t        resolve_o,
  output logic [bru_pkg::XLEN-1:0] link_o,
  output bru_pkg::exc_t            exc_o
);

  // operation class of the registered item
  logic                     is_branch;
  logic                     is_jalr;
  logic                     taken;

  // address arithmetic
  logic [bru_pkg::XLEN-1:0] pc_step;
  logic [bru_pkg::XLEN-1:0] next_pc;
  logic [bru_pkg::XLEN-1:0] jump_base;
  logic [bru_pkg::XLEN-1:0] target_address;

  // prediction checks
  logic                     predicted_branch;
  logic                     jalr_mispredict;
  logic                     misaligned;

  assign is_branch = bru_pkg::op_is_branch(stage_i.req.op);
  assign is_jalr   = stage_i.req.op == bru_pkg::JALR;

  // conditional branches follow the comparison, JAL and JALR always jump
  assign taken = is_branch ? stage_i.comp_res : 1'b1;

  // a compressed instruction is 2 bytes long, a full one 4 bytes
  always_comb begin
    pc_step      = '0;
    pc_step[2:1] = stage_i.req.is_compressed ? 2'b01 : 2'b10;
  end

  // the link value is written to rd and is also the fall-through address
  assign next_pc = stage_i.req.pc + pc_step;
  assign link_o  = next_pc;

  // JALR jumps relative to rs1, every other operation relative to the pc
  assign jump_base = is_jalr ? stage_i.req.operand_a : stage_i.req.pc;

  always_comb begin
    target_address = jump_base + stage_i.req.imm;
    // the ISA requires JALR to drop the lowest bit of the sum
    if (is_jalr) begin
      target_address[0] = 1'b0;
    end
  end

  // the front end guessed taken only if it tagged the item as a branch
  assign predicted_branch = stage_i.req.predict.cf == bru_pkg::BRANCH;

  // a register jump is wrong if nothing was predicted or the address differs
  assign jalr_mispredict = is_jalr &&
                           (stage_i.req.predict.cf == bru_pkg::NO_CF ||
                            stage_i.req.predict.predict_address != target_address);

  // resolution of the registered item
  always_comb begin
    resolve_o.valid          = stage_i.valid;
    resolve_o.pc             = stage_i.req.pc;
    resolve_o.target_address = '0;
    resolve_o.is_taken       = 1'b0;
    resolve_o.is_mispredict  = 1'b0;
    // by default the predicted type is handed back unchanged, e.g. for JAL
    resolve_o.cf_type        = stage_i.req.predict.cf;
    if (stage_i.valid) begin
      // not taken means the front end continues at the link value
      resolve_o.target_address = taken ? target_address : next_pc;
      resolve_o.is_taken       = taken;
      if (is_branch) begin
        // branches always update the history table
        resolve_o.cf_type       = bru_pkg::BRANCH;
        resolve_o.is_mispredict = taken != predicted_branch;
      end
      if (jalr_mispredict) begin
        resolve_o.is_mispredict = 1'b1;
        // a return stays a return so the return stack is not confused with the BTB
        if (stage_i.req.predict.cf != bru_pkg::RETURN) begin
          resolve_o.cf_type = bru_pkg::JUMP_R;
        end
      end
    end
  end

  // without compressed support targets must sit on a 4 byte boundary,
  // with it a 2 byte boundary is enough
  assign misaligned = target_address[0] || (!rvc_en_i && target_address[1]);

  // only a jump that is actually taken can fault, a not-taken branch
  // never fetches from its target
  always_comb begin
    exc_o.valid = stage_i.valid && taken && misaligned;
    exc_o.cause = bru_pkg::INSTR_ADDR_MISALIGNED;
    // tval reports the pc of the faulting control-flow instruction
    exc_o.tval  = stage_i.req.pc;
  end

endmodule

// File: bru_cfg_regs.sv
// configuration register with the compressed enable and the resolve and mispredict counters
`timescale 1ns/1ps

module bru_cfg_regs #(
  parameter int unsigned CNT_W = 16
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     cfg_we_i,
  input  bru_pkg::cfg_addr_e       cfg_addr_i,
  input  logic [bru_pkg::XLEN-1:0] cfg_wdata_i,
  output logic [bru_pkg::XLEN-1:0] cfg_rdata_o,
  input  bru_pkg::resolve_t        resolve_i,
  output logic                     rvc_en_o
);

  // register state
  logic             rvc_en_q;
  logic [CNT_W-1:0] resolved_cnt_q;
  logic [CNT_W-1:0] mispredict_cnt_q;

  // decoded write strobes
  logic             wr_ctrl;
  logic             clr_resolved;
  logic             clr_mispredict;

  assign wr_ctrl        = cfg_we_i && cfg_addr_i == bru_pkg::CFG_CTRL;
  assign clr_resolved   = cfg_we_i && cfg_addr_i == bru_pkg::CFG_RESOLVED;
  assign clr_mispredict = cfg_we_i && cfg_addr_i == bru_pkg::CFG_MISPREDICT;

  // compressed instructions are enabled out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvc_en_q <= 1'b1;
    end else if (wr_ctrl) begin
      rvc_en_q <= cfg_wdata_i[0];
    end
  end

  // counters wrap at CNT_W bits
  // a software clear on the same edge as an event wins over the increment
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resolved_cnt_q   <= '0;
      mispredict_cnt_q <= '0;
    end else begin
      if (clr_resolved) begin
        resolved_cnt_q <= '0;
      end else if (resolve_i.valid) begin
        resolved_cnt_q <= resolved_cnt_q + 1'b1;
      end
      // only valid resolutions can count as mispredicts
      if (clr_mispredict) begin
        mispredict_cnt_q <= '0;
      end else if (resolve_i.valid && resolve_i.is_mispredict) begin
        mispredict_cnt_q <= mispredict_cnt_q + 1'b1;
      end
    end
  end

  // combinational read, narrower fields are zero-extended to XLEN
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      bru_pkg::CFG_CTRL:       cfg_rdata_o[0]         = rvc_en_q;
      bru_pkg::CFG_RESOLVED:   cfg_rdata_o[CNT_W-1:0] = resolved_cnt_q;
      bru_pkg::CFG_MISPREDICT: cfg_rdata_o[CNT_W-1:0] = mispredict_cnt_q;
      // the unmapped address reads as zero
      default:                 cfg_rdata_o            = '0;
    endcase
  end

  assign rvc_en_o = rvc_en_q;

endmodule

// File: bru_top.sv
// branch resolution top level joining compare stage, branch unit and register block
`timescale 1ns/1ps

module bru_top #(
  // width of the two event counters in the register block
  parameter int unsigned CNT_W = 16
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // issue side, one item per cycle at most
  input  logic                     issue_valid_i,
  input  bru_pkg::br_req_t         issue_req_i,
  // configuration port
  input  logic                     cfg_we_i,
  input  bru_pkg::cfg_addr_e       cfg_addr_i,
  input  logic [bru_pkg::XLEN-1:0] cfg_wdata_i,
  output logic [bru_pkg::XLEN-1:0] cfg_rdata_o,
  // results, valid one cycle after the issue
  output bru_pkg::resolve_t        resolve_o,
  output logic [bru_pkg::XLEN-1:0] link_o,
  output bru_pkg::exc_t            exc_o
);

  // registered item between compare stage and branch unit
  bru_pkg::br_stage_t stage;
  // compressed enable from the register block
  logic               rvc_en;

  branch_compare u_branch_compare (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_req_i   (issue_req_i),
    .stage_o       (stage)
  );

  branch_unit u_branch_unit (
    .stage_i   (stage),
    .rvc_en_i  (rvc_en),
    .resolve_o (resolve_o),
    .link_o    (link_o),
    .exc_o     (exc_o)
  );

  // the counters watch the same resolution that leaves the top level
  bru_cfg_regs #(
    .CNT_W (CNT_W)
  ) u_bru_cfg_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .resolve_i   (resolve_o),
    .rvc_en_o    (rvc_en)
  );

endmodule

// File: bru_asserts.sv
// concurrent assertions on resolution timing, reset, exception cause and jalr targets
`timescale 1ns/1ps

module bru_asserts (
  input logic               clk_i,
  input logic               arst_n_i,
  input logic               issue_valid_i,
  input bru_pkg::br_stage_t stage_i,
  input bru_pkg::resolve_t  resolve_i,
  input bru_pkg::exc_t      exc_i
);

  // a sampled issue resolves exactly one edge later and nothing resolves without one
  issue_to_resolve: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_valid_i |=> resolve_i.valid)
    else $error("resolution missing one cycle after an issue");

  no_issue_no_resolve: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !issue_valid_i |=> !resolve_i.valid)
    else $error("resolution seen without an issue one cycle before");

  // the stage register is cleared asynchronously
  quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !resolve_i.valid)
    else $error("resolution valid while reset is asserted");

  exc_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exc_i.valid |-> exc_i.cause == bru_pkg::INSTR_ADDR_MISALIGNED)
    else $error("exception raised with an unexpected cause");

  jalr_even_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stage_i.valid && stage_i.req.op == bru_pkg::JALR |-> !resolve_i.target_address[0])
    else $error("jalr target with bit 0 set");

endmodule

// File: tb_bru.sv
// directed testbench for the branch resolution unit with reference model, compare tasks and report
`timescale 1ns/1ps

module tb_bru;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     issue_valid_i;
  bru_pkg::br_req_t         issue_req_i;
  logic                     cfg_we_i;
  bru_pkg::cfg_addr_e       cfg_addr_i;
  logic [bru_pkg::XLEN-1:0] cfg_wdata_i;
  logic [bru_pkg::XLEN-1:0] cfg_rdata_o;
  bru_pkg::resolve_t        resolve_o;
  logic [bru_pkg::XLEN-1:0] link_o;
  bru_pkg::exc_t            exc_o;

  // wrong values and failures of any other kind are counted apart
  int unsigned value_errors;
  int unsigned other_errors;
  // software view of the register block, kept in step with every issue and write
  logic        rvc_en_model;
  int unsigned exp_resolved;
  int unsigned exp_mispredict;

  bru_top #(
    .CNT_W (16)
  ) u_dut (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_req_i   (issue_req_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_rdata_o   (cfg_rdata_o),
    .resolve_o     (resolve_o),
    .link_o        (link_o),
    .exc_o         (exc_o)
  );

  // the checker also watches the registered stage inside the top level
  bind bru_top bru_asserts u_bru_asserts (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .issue_valid_i (issue_valid_i),
    .stage_i       (stage),
    .resolve_i     (resolve_o),
    .exc_i         (exc_o)
  );

  // 8 ns clock period
  always #4 clk_i = ~clk_i;

  // expected outputs for one item, built from the ISA rules of the stage
  function automatic void reference_model(
    input  bru_pkg::br_req_t         req,
    input  logic                     rvc_en,
    output bru_pkg::resolve_t        res,
    output logic [bru_pkg::XLEN-1:0] link,
    output bru_pkg::exc_t            exc
  );
    logic                     branch;
    logic                     cond;
    logic                     taken;
    logic [bru_pkg::XLEN-1:0] target;
    logic [bru_pkg::XLEN-1:0] sa;
    logic [bru_pkg::XLEN-1:0] sb;
    branch = 1'b1;
    cond   = 1'b0;
    // flipping the sign bit turns a signed compare into an unsigned one
    sa     = req.operand_a ^ 32'h8000_0000;
    sb     = req.operand_b ^ 32'h8000_0000;
    case (req.op)
      bru_pkg::BEQ:  cond = req.operand_a == req.operand_b;
      bru_pkg::BNE:  cond = req.operand_a != req.operand_b;
      bru_pkg::BLT:  cond = sa < sb;
      bru_pkg::BGE:  cond = !(sa < sb);
      bru_pkg::BLTU: cond = req.operand_a < req.operand_b;
      bru_pkg::BGEU: cond = !(req.operand_a < req.operand_b);
      default:       branch = 1'b0;
    endcase
    taken = branch ? cond : 1'b1;
    link  = req.pc + (req.is_compressed ? 32'd2 : 32'd4);
    if (req.op == bru_pkg::JALR) begin
      target = (req.operand_a + req.imm) & ~32'd1;
    end else begin
      target = req.pc + req.imm;
    end
    res.valid          = 1'b1;
    res.pc             = req.pc;
    res.target_address = taken ? target : link;
    res.is_taken       = taken;
    res.is_mispredict  = 1'b0;
    res.cf_type        = req.predict.cf;
    if (branch) begin
      res.cf_type       = bru_pkg::BRANCH;
      res.is_mispredict = taken != (req.predict.cf == bru_pkg::BRANCH);
    end else if (req.op == bru_pkg::JALR && (req.predict.cf == bru_pkg::NO_CF ||
                 req.predict.predict_address != target)) begin
      res.is_mispredict = 1'b1;
      res.cf_type       = (req.predict.cf == bru_pkg::RETURN) ? bru_pkg::RETURN : bru_pkg::JUMP_R;
    end
    exc.valid = taken && (target[0] || (!rvc_en && target[1]));
    exc.cause = bru_pkg::INSTR_ADDR_MISALIGNED;
    exc.tval  = req.pc;
  endfunction

  function automatic bru_pkg::br_req_t make_req(
    input bru_pkg::fu_op_e          op,
    input logic [bru_pkg::XLEN-1:0] a,
    input logic [bru_pkg::XLEN-1:0] b,
    input logic [bru_pkg::XLEN-1:0] imm,
    input logic [bru_pkg::XLEN-1:0] pc,
    input logic                     compressed,
    input bru_pkg::cf_e             cf,
    input logic [bru_pkg::XLEN-1:0] paddr
  );
    bru_pkg::br_req_t req;
    req.op                      = op;
    req.operand_a               = a;
    req.operand_b               = b;
    req.imm                     = imm;
    req.pc                      = pc;
    req.is_compressed           = compressed;
    req.predict.cf              = cf;
    req.predict.predict_address = paddr;
    return req;
  endfunction

  task automatic check_resolve(input string name, input bru_pkg::resolve_t got,
                               input bru_pkg::resolve_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // cause and tval only carry meaning while the exception is valid
  task automatic check_exc(input string name, input bru_pkg::exc_t got, input bru_pkg::exc_t exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
      value_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [bru_pkg::XLEN-1:0] got,
                            input logic [bru_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic wait_resolve(output bit seen);
    int unsigned cycles;
    cycles = 0;
    seen   = 1'b1;
    while (resolve_o.valid !== 1'b1) begin
      if (cycles == 20) begin
        other_errors++;
        $display("no resolution came out within 20 cycles of an issue");
        seen = 1'b0;
        break;
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  // compares the current resolution with the model and advances the expected counters
  task automatic check_result(input bru_pkg::br_req_t req);
    bru_pkg::resolve_t        exp_res;
    logic [bru_pkg::XLEN-1:0] exp_link;
    bru_pkg::exc_t            exp_exc;
    bit                       seen;
    reference_model(req, rvc_en_model, exp_res, exp_link, exp_exc);
    wait_resolve(seen);
    if (seen) begin
      check_resolve("resolve_o", resolve_o, exp_res);
      check_word("link_o", link_o, exp_link);
      check_exc("exc_o", exc_o, exp_exc);
    end
    exp_resolved++;
    if (exp_res.is_mispredict) begin
      exp_mispredict++;
    end
  endtask

  task automatic issue_one(input bru_pkg::br_req_t req);
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b1;
    issue_req_i   = req;
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
    check_result(req);
  endtask

  task automatic write_reg(input bru_pkg::cfg_addr_e addr, input logic [bru_pkg::XLEN-1:0] data);
    @(posedge clk_i);
    #1;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
  endtask

  // reads are combinational, so the data is sampled 1 ns after the address settles
  task automatic read_check(input string name, input bru_pkg::cfg_addr_e addr,
                            input logic [bru_pkg::XLEN-1:0] exp);
    @(posedge clk_i);
    #1;
    cfg_addr_i = addr;
    #1;
    check_word(name, cfg_rdata_o, exp);
  endtask

  task automatic reset_values();
    read_check("cfg ctrl", bru_pkg::CFG_CTRL, 32'd1);
    read_check("cfg resolved", bru_pkg::CFG_RESOLVED, 32'd0);
    read_check("cfg mispredict", bru_pkg::CFG_MISPREDICT, 32'd0);
  endtask

  // all six conditions on random, equal and sign boundary operands, both lengths
  task automatic conditional_ops();
    logic [bru_pkg::XLEN-1:0] a_val [5];
    logic [bru_pkg::XLEN-1:0] b_val [5];
    logic [bru_pkg::XLEN-1:0] imm;
    logic [bru_pkg::XLEN-1:0] pc;
    a_val[0] = $urandom();
    b_val[0] = $urandom();
    a_val[1] = $urandom();
    b_val[1] = a_val[1];
    a_val[2] = 32'h7fff_ffff;
    b_val[2] = 32'h8000_0000;
    a_val[3] = 32'h8000_0000;
    b_val[3] = 32'h7fff_ffff;
    a_val[4] = 32'hffff_ffff;
    b_val[4] = 32'h0000_0001;
    for (int op = 0; op < 6; op++) begin
      for (int k = 0; k < 5; k++) begin
        for (int c = 0; c < 2; c++) begin
          // word aligned targets keep these items free of exceptions
          imm = ($urandom() & 32'h1ffc) - 32'h1000;
          pc  = $urandom() & 32'hffff_fffc;
          issue_one(make_req(bru_pkg::fu_op_e'(3'(op)), a_val[k], b_val[k], imm, pc,
                             c[0], bru_pkg::NO_CF, 32'd0));
        end
      end
    end
  endtask

  task automatic mispredict_cases();
    logic [bru_pkg::XLEN-1:0] base;
    logic [bru_pkg::XLEN-1:0] tgt;
    // BEQ taken and not taken, predicted as a branch and as nothing
    issue_one(make_req(bru_pkg::BEQ, 32'd5, 32'd5, 32'h40, 32'h100, 1'b0, bru_pkg::BRANCH, 32'h140));
    issue_one(make_req(bru_pkg::BEQ, 32'd5, 32'd5, 32'h40, 32'h100, 1'b0, bru_pkg::NO_CF, 32'd0));
    issue_one(make_req(bru_pkg::BEQ, 32'd5, 32'd6, 32'h40, 32'h100, 1'b0, bru_pkg::BRANCH, 32'h140));
    issue_one(make_req(bru_pkg::BEQ, 32'd5, 32'd6, 32'h40, 32'h100, 1'b0, bru_pkg::NO_CF, 32'd0));
    base = $urandom() & 32'hffff_fff0;
    tgt  = base + 32'h24;
    issue_one(make_req(bru_pkg::JALR, base, 32'd0, 32'h24, 32'h200, 1'b0, bru_pkg::JUMP_R, tgt));
    issue_one(make_req(bru_pkg::JALR, base, 32'd0, 32'h24, 32'h200, 1'b0, bru_pkg::JUMP_R,
                       tgt + 32'd4));
    issue_one(make_req(bru_pkg::JALR, base, 32'd0, 32'h24, 32'h200, 1'b0, bru_pkg::NO_CF, tgt));
    issue_one(make_req(bru_pkg::JALR, base, 32'd0, 32'h24, 32'h200, 1'b1, bru_pkg::RETURN,
                       tgt + 32'd8));
    issue_one(make_req(bru_pkg::JALR, base, 32'd0, 32'h24, 32'h200, 1'b1, bru_pkg::RETURN, tgt));
  endtask

  task automatic jump_targets();
    logic [bru_pkg::XLEN-1:0] imm;
    imm = ($urandom() & 32'hf_fffc) - 32'h8_0000;
    issue_one(make_req(bru_pkg::JAL, 32'd0, 32'd0, imm, 32'h0001_0000, 1'b0, bru_pkg::JUMP,
                       32'h0001_0000 + imm));
    // odd sums from either an odd base or an odd offset lose bit 0
    issue_one(make_req(bru_pkg::JALR, 32'h1000_0001, 32'd0, 32'h10, 32'h300, 1'b0,
                       bru_pkg::JUMP_R, 32'h1000_0010));
    issue_one(make_req(bru_pkg::JALR, 32'h2000_0000, 32'd0, 32'h7, 32'h304, 1'b1,
                       bru_pkg::JUMP_R, 32'h2000_0006));
  endtask

  task automatic misaligned_targets();
    // a half-word target is legal while compressed instructions are on
    issue_one(make_req(bru_pkg::JAL, 32'd0, 32'd0, 32'h6, 32'h2000, 1'b0, bru_pkg::JUMP, 32'h2006));
    write_reg(bru_pkg::CFG_CTRL, 32'd0);
    rvc_en_model = 1'b0;
    read_check("cfg ctrl", bru_pkg::CFG_CTRL, 32'd0);
    issue_one(make_req(bru_pkg::JAL, 32'd0, 32'd0, 32'h6, 32'h2000, 1'b0, bru_pkg::JUMP, 32'h2006));
    // a branch that falls through never faults on its target
    issue_one(make_req(bru_pkg::BEQ, 32'd1, 32'd2, 32'h6, 32'h2000, 1'b0, bru_pkg::NO_CF, 32'd0));
    write_reg(bru_pkg::CFG_CTRL, 32'd1);
    rvc_en_model = 1'b1;
    read_check("cfg ctrl", bru_pkg::CFG_CTRL, 32'd1);
  endtask

  // one new item on every edge, each result must show up in the cycle after its issue
  task automatic back_to_back();
    bru_pkg::br_req_t reqs [4];
    reqs[0] = make_req(bru_pkg::BEQ, 32'd9, 32'd9, 32'h80, 32'h400, 1'b0, bru_pkg::BRANCH, 32'h480);
    reqs[1] = make_req(bru_pkg::BNE, 32'd9, 32'd9, 32'h80, 32'h404, 1'b1, bru_pkg::BRANCH, 32'h484);
    reqs[2] = make_req(bru_pkg::JAL, 32'd0, 32'd0, 32'h100, 32'h406, 1'b1, bru_pkg::JUMP, 32'h506);
    reqs[3] = make_req(bru_pkg::JALR, 32'h800, 32'd0, 32'h4, 32'h408, 1'b0, bru_pkg::NO_CF, 32'd0);
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b1;
    issue_req_i   = reqs[0];
    for (int i = 1; i < 4; i++) begin
      @(posedge clk_i);
      #1;
      issue_req_i = reqs[i];
      check_result(reqs[i-1]);
    end
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
    check_result(reqs[3]);
  endtask

  task automatic counter_checks();
    read_check("cfg resolved", bru_pkg::CFG_RESOLVED, exp_resolved);
    read_check("cfg mispredict", bru_pkg::CFG_MISPREDICT, exp_mispredict);
    write_reg(bru_pkg::CFG_RESOLVED, 32'd0);
    read_check("cfg resolved", bru_pkg::CFG_RESOLVED, 32'd0);
    read_check("cfg mispredict", bru_pkg::CFG_MISPREDICT, exp_mispredict);
    write_reg(bru_pkg::CFG_MISPREDICT, 32'd0);
    read_check("cfg mispredict", bru_pkg::CFG_MISPREDICT, 32'd0);
  endtask

  initial begin
    void'($urandom(32'h6567_a597));
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    issue_valid_i  = 1'b0;
    issue_req_i    = '0;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = bru_pkg::CFG_CTRL;
    cfg_wdata_i    = '0;
    value_errors   = 0;
    other_errors   = 0;
    rvc_en_model   = 1'b1;
    exp_resolved   = 0;
    exp_mispredict = 0;
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    reset_values();
    conditional_ops();
    mispredict_cases();
    jump_targets();
    misaligned_targets();
    back_to_back();
    counter_checks();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
bru_pkg.sv
branch_compare.sv
branch_unit.sv
bru_cfg_regs.sv
bru_top.sv
bru_asserts.sv
tb_bru.sv

// File: Makefile
# Verilator build and run of the branch resolution testbench

SRCS := $(filter %.sv,$(shell cat tb.f))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_bru: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_bru -f tb.f -o Vtb_bru

# the run passes only if the log holds the pass line
run: obj_dir/Vtb_bru
	./obj_dir/Vtb_bru | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
